// ==== verilog/core_macros.svh ====
//////////////////////////////////////////////////
// rename core sizes
// lane count, queue depths and data widths
//////////////////////////////////////////////////

`ifndef core_macros_svh
`define core_macros_svh

// lanes handled per cycle at every stage
`define WIDTH      2

`define ARCH_REGS  8
`define ROB_DEPTH  8
`define PHYS_REGS  16   // arch regs plus one per rob slot
`define IB_DEPTH   8

`define DATA_BITS  16
`define IMM_BITS   16

`endif

// ==== verilog/isa_pkg.sv ====
//////////////////////////////////////////////////
// architectural view of the reduced isa
// instruction word, opcodes and commit record
//////////////////////////////////////////////////

`include "core_macros.svh"

package isa_pkg;

    typedef enum logic [1:0] {
        op_add,
        op_sub,
        op_xor,
        op_li     // dest = imm, no sources
    } opcode_t;

    typedef logic [$clog2(`ARCH_REGS)-1:0] arch_idx_t;
    typedef logic [`DATA_BITS-1:0]         data_t;

    typedef struct packed {
        logic      valid;
        opcode_t   opcode;
        arch_idx_t dest;
        arch_idx_t src1;
        arch_idx_t src2;
        data_t     imm;
    } inst_t;

    // one retired instruction as seen outside the core
    typedef struct packed {
        logic      valid;
        arch_idx_t dest;
        data_t     data;
    } commit_t;

endpackage

// ==== verilog/uarch_pkg.sv ====
//////////////////////////////////////////////////
// microarchitecture records
// physical tags, rob entries and issued alu ops
//////////////////////////////////////////////////

`include "core_macros.svh"

package uarch_pkg;

    typedef logic [$clog2(`PHYS_REGS)-1:0] phys_idx_t;
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;

    typedef struct packed {
        isa_pkg::arch_idx_t dest;
        phys_idx_t          t_new;
        phys_idx_t          t_old;   // freed when this entry retires
        logic               done;
    } rob_entry_t;

    // operands already read from the register file
    typedef struct packed {
        logic              valid;
        isa_pkg::opcode_t  opcode;
        phys_idx_t         t_new;
        rob_idx_t          rob_slot;
        isa_pkg::data_t    op_a;
        isa_pkg::data_t    op_b;   // holds imm for li
    } exec_op_t;

endpackage

// ==== verilog/inst_buffer.sv ====
//////////////////////////////////////////////////
// instruction buffer
// ring of incoming instructions, up to WIDTH
// pushed and popped each cycle
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "core_macros.svh"

module inst_buffer (
    input  logic                                 clock,
    input  logic                                 reset,
    input  isa_pkg::inst_t [`WIDTH-1:0]          push_insts,
    input  logic [$clog2(`WIDTH+1)-1:0]          push_count,
    input  logic [$clog2(`WIDTH+1)-1:0]          pop_count,
    output isa_pkg::inst_t [`WIDTH-1:0]          head_insts,
    output logic [$clog2(`IB_DEPTH+1)-1:0]       count,
    output logic [$clog2(`IB_DEPTH+1)-1:0]       open
);

    localparam int PTR_BITS = $clog2(`IB_DEPTH);
    localparam int CNT_BITS = $clog2(`IB_DEPTH+1);

    typedef logic [PTR_BITS-1:0] ptr_t;
    typedef logic [CNT_BITS-1:0] cnt_t;

    isa_pkg::inst_t mem [`IB_DEPTH];
    ptr_t           head;
    ptr_t           tail;

    assign open = cnt_t'(`IB_DEPTH) - count;

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + ptr_t'(pop_count);
            tail  <= tail + ptr_t'(push_count);
            count <= count + cnt_t'(push_count) - cnt_t'(pop_count);
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < `WIDTH; i++) begin
            if (i < push_count) mem[tail + ptr_t'(i)] <= push_insts[i];
        end
    end

    // oldest entries, lanes past count are stale
    always_comb begin
        for (int i = 0; i < `WIDTH; i++) head_insts[i] = mem[head + ptr_t'(i)];
    end

    a_push_fits: assert property (@(posedge clock) disable iff (reset) push_count <= open);
    a_pop_fits:  assert property (@(posedge clock) disable iff (reset) pop_count <= count);

endmodule

// ==== verilog/dispatch_select.sv ====
//////////////////////////////////////////////////
// dispatch select
// in-order count of head instructions that can
// rename and issue this cycle
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "core_macros.svh"

module dispatch_select (
    input  isa_pkg::inst_t [`WIDTH-1:0]          head_insts,
    input  logic [$clog2(`IB_DEPTH+1)-1:0]       head_count,
    input  logic [$clog2(`ROB_DEPTH+1)-1:0]      rob_open,
    input  logic [$clog2(`ROB_DEPTH+1)-1:0]      free_count,
    input  uarch_pkg::phys_idx_t [`WIDTH-1:0]    src1_phys,
    input  uarch_pkg::phys_idx_t [`WIDTH-1:0]    src2_phys,
    input  logic [`PHYS_REGS-1:0]                phys_ready,
    output logic [$clog2(`WIDTH+1)-1:0]          num_dispatch
);

    always_comb begin
        logic stop;
        logic ok;
        logic has_srcs;
        num_dispatch = '0;
        stop = 1'b0;
        for (int i = 0; i < `WIDTH; i++) begin
            has_srcs = (head_insts[i].opcode != isa_pkg::op_li);
            ok = (i < head_count) && (i < rob_open) && (i < free_count);
            if (has_srcs) ok = ok && phys_ready[src1_phys[i]] && phys_ready[src2_phys[i]];
            // producer in the same group has not executed yet
            for (int j = 0; j < i; j++) begin
                if (has_srcs && (head_insts[j].dest == head_insts[i].src1 ||
                                 head_insts[j].dest == head_insts[i].src2)) ok = 1'b0;
            end
            if (!stop && ok) num_dispatch = num_dispatch + 1'b1;
            else stop = 1'b1;   // prefix only
        end
    end

endmodule

// ==== verilog/rename_unit.sv ====
//////////////////////////////////////////////////
// rename unit
// map table plus free-list ring, renames a group
// and takes back retired registers
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "core_macros.svh"

module rename_unit (
    input  logic                                 clock,
    input  logic                                 reset,
    input  isa_pkg::inst_t [`WIDTH-1:0]          insts,
    input  logic [$clog2(`WIDTH+1)-1:0]          num_dispatch,
    input  logic [$clog2(`WIDTH+1)-1:0]          retire_count,
    input  uarch_pkg::phys_idx_t [`WIDTH-1:0]    retire_t_old,
    output uarch_pkg::phys_idx_t [`WIDTH-1:0]    src1_phys,
    output uarch_pkg::phys_idx_t [`WIDTH-1:0]    src2_phys,
    output uarch_pkg::phys_idx_t [`WIDTH-1:0]    t_new,
    output uarch_pkg::phys_idx_t [`WIDTH-1:0]    t_old,
    output logic [$clog2(`ROB_DEPTH+1)-1:0]      free_count
);

    localparam int PTR_BITS = $clog2(`ROB_DEPTH);
    localparam int CNT_BITS = $clog2(`ROB_DEPTH+1);

    typedef logic [PTR_BITS-1:0] ptr_t;
    typedef logic [CNT_BITS-1:0] cnt_t;

    uarch_pkg::phys_idx_t map  [`ARCH_REGS];
    uarch_pkg::phys_idx_t fl   [`ROB_DEPTH];   // free list ring
    ptr_t                 fl_head;
    ptr_t                 fl_tail;

    //////////////////////////////////////////////////
    // group lookup
    //////////////////////////////////////////////////

    // every lane is renamed as if the whole group goes, so the
    // lookup never depends on num_dispatch
    always_comb begin
        uarch_pkg::phys_idx_t lookup [`ARCH_REGS];
        lookup = map;
        for (int i = 0; i < `WIDTH; i++) begin
            t_new[i]     = fl[fl_head + ptr_t'(i)];
            src1_phys[i] = lookup[insts[i].src1];
            src2_phys[i] = lookup[insts[i].src2];
            t_old[i]     = lookup[insts[i].dest];
            lookup[insts[i].dest] = t_new[i];   // seen by later lanes
        end
    end

    //////////////////////////////////////////////////
    // state update
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `ARCH_REGS; i++) map[i] <= uarch_pkg::phys_idx_t'(i);
            for (int i = 0; i < `ROB_DEPTH; i++) fl[i] <= uarch_pkg::phys_idx_t'(`ARCH_REGS + i);
            fl_head    <= '0;
            fl_tail    <= '0;
            free_count <= cnt_t'(`ROB_DEPTH);
        end else begin
            // later lane wins on a shared dest
            for (int i = 0; i < `WIDTH; i++) begin
                if (i < num_dispatch) map[insts[i].dest] <= t_new[i];
            end
            for (int i = 0; i < `WIDTH; i++) begin
                if (i < retire_count) fl[fl_tail + ptr_t'(i)] <= retire_t_old[i];
            end
            fl_head    <= fl_head + ptr_t'(num_dispatch);
            fl_tail    <= fl_tail + ptr_t'(retire_count);
            free_count <= free_count + cnt_t'(retire_count) - cnt_t'(num_dispatch);
        end
    end

    a_fl_underflow: assert property (@(posedge clock) disable iff (reset)
        num_dispatch <= free_count);

endmodule

// ==== verilog/phys_regfile.sv ====
//////////////////////////////////////////////////
// physical register file
// values plus ready bits, 2*WIDTH reads and
// WIDTH writeback ports
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "core_macros.svh"

module phys_regfile (
    input  logic                                 clock,
    input  logic                                 reset,
    input  uarch_pkg::phys_idx_t [2*`WIDTH-1:0]  read_idx,
    output isa_pkg::data_t [2*`WIDTH-1:0]        read_data,
    output logic [`PHYS_REGS-1:0]                ready,
    input  uarch_pkg::phys_idx_t [`WIDTH-1:0]    alloc_idx,
    input  logic [$clog2(`WIDTH+1)-1:0]          alloc_count,
    input  logic [`WIDTH-1:0]                    wb_valid,
    input  uarch_pkg::phys_idx_t [`WIDTH-1:0]    wb_idx,
    input  isa_pkg::data_t [`WIDTH-1:0]          wb_data
);

    isa_pkg::data_t regs [`PHYS_REGS];

    always_comb begin
        for (int i = 0; i < 2*`WIDTH; i++) read_data[i] = regs[read_idx[i]];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `PHYS_REGS; i++) begin
                regs[i]  <= '0;
                ready[i] <= (i < `ARCH_REGS);   // initial arch mapping
            end
        end else begin
            for (int i = 0; i < `WIDTH; i++) begin
                if (wb_valid[i]) begin
                    regs[wb_idx[i]]  <= wb_data[i];
                    ready[wb_idx[i]] <= 1'b1;
                end
            end
            // new dest waits for its producer
            for (int i = 0; i < `WIDTH; i++) begin
                if (i < alloc_count) ready[alloc_idx[i]] <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/alu_lane.sv ====
//////////////////////////////////////////////////
// alu lane
// one-cycle execute stage for a single lane
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "core_macros.svh"

module alu_lane (
    input  logic                    clock,
    input  logic                    reset,
    input  uarch_pkg::exec_op_t     op_in,
    output logic                    wb_valid,
    output uarch_pkg::phys_idx_t    wb_idx,
    output uarch_pkg::rob_idx_t     wb_slot,
    output isa_pkg::data_t          wb_data
);

    uarch_pkg::exec_op_t op_q;

    always_ff @(posedge clock) begin
        if (reset) wb_valid <= 1'b0;
        else wb_valid <= op_in.valid;
    end

    always_ff @(posedge clock) op_q <= op_in;

    assign wb_idx  = op_q.t_new;
    assign wb_slot = op_q.rob_slot;

    always_comb begin
        case (op_q.opcode)
            isa_pkg::op_add: wb_data = op_q.op_a + op_q.op_b;
            isa_pkg::op_sub: wb_data = op_q.op_a - op_q.op_b;
            isa_pkg::op_xor: wb_data = op_q.op_a ^ op_q.op_b;
            default:         wb_data = op_q.op_b;   // li
        endcase
    end

endmodule

// ==== verilog/reorder_buffer.sv ====
//////////////////////////////////////////////////
// reorder buffer
// tracks completion, retires up to WIDTH done
// entries per cycle in program order
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "core_macros.svh"

module reorder_buffer (
    input  logic                                  clock,
    input  logic                                  reset,
    input  uarch_pkg::rob_entry_t [`WIDTH-1:0]    alloc_entries,
    input  logic [$clog2(`WIDTH+1)-1:0]           alloc_count,
    output uarch_pkg::rob_idx_t [`WIDTH-1:0]      alloc_slots,
    output logic [$clog2(`ROB_DEPTH+1)-1:0]       open,
    input  logic [`WIDTH-1:0]                     wb_valid,
    input  uarch_pkg::rob_idx_t [`WIDTH-1:0]      wb_slot,
    input  isa_pkg::data_t [`WIDTH-1:0]           wb_data,
    output isa_pkg::commit_t [`WIDTH-1:0]         commit,
    output logic [$clog2(`WIDTH+1)-1:0]           retire_count,
    output uarch_pkg::phys_idx_t [`WIDTH-1:0]     retire_t_old
);

    localparam int CNT_BITS = $clog2(`ROB_DEPTH+1);

    typedef logic [CNT_BITS-1:0] cnt_t;

    uarch_pkg::rob_entry_t entries [`ROB_DEPTH];
    isa_pkg::data_t        results [`ROB_DEPTH];
    uarch_pkg::rob_idx_t   head;
    uarch_pkg::rob_idx_t   tail;
    cnt_t                  count;

    assign open = cnt_t'(`ROB_DEPTH) - count;

    always_comb begin
        for (int i = 0; i < `WIDTH; i++) alloc_slots[i] = tail + uarch_pkg::rob_idx_t'(i);
    end

    //////////////////////////////////////////////////
    // retire the longest done prefix at the head
    //////////////////////////////////////////////////

    always_comb begin
        logic                stop;
        uarch_pkg::rob_idx_t slot;
        retire_count = '0;
        stop = 1'b0;
        for (int i = 0; i < `WIDTH; i++) begin
            slot = head + uarch_pkg::rob_idx_t'(i);
            if (!stop && (i < count) && entries[slot].done) retire_count = retire_count + 1'b1;
            else stop = 1'b1;
            commit[i].valid = !stop;
            commit[i].dest  = entries[slot].dest;
            commit[i].data  = results[slot];
            retire_t_old[i] = entries[slot].t_old;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + uarch_pkg::rob_idx_t'(retire_count);
            tail  <= tail + uarch_pkg::rob_idx_t'(alloc_count);
            count <= count + cnt_t'(alloc_count) - cnt_t'(retire_count);
        end
    end

    // writeback marks done, dispatch fills new entries
    always_ff @(posedge clock) begin
        for (int i = 0; i < `WIDTH; i++) begin
            if (wb_valid[i]) begin
                entries[wb_slot[i]].done <= 1'b1;
                results[wb_slot[i]]      <= wb_data[i];
            end
        end
        for (int i = 0; i < `WIDTH; i++) begin
            if (i < alloc_count) entries[alloc_slots[i]] <= alloc_entries[i];
        end
    end

    for (genvar i = 0; i < `WIDTH; i++) begin : g_wb_check
        a_wb_live: assert property (@(posedge clock) disable iff (reset)
            wb_valid[i] |-> (cnt_t'(uarch_pkg::rob_idx_t'(wb_slot[i] - head)) < count));
    end

endmodule

// ==== verilog/rename_core.sv ====
//////////////////////////////////////////////////
// rename core top level
// buffer, dispatch, rename, regfile, two alu
// lanes and the reorder buffer
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "core_macros.svh"

module rename_core (
    input  logic                                 clock,
    input  logic                                 reset,
    input  isa_pkg::inst_t [`WIDTH-1:0]          in_insts,
    input  logic [$clog2(`WIDTH+1)-1:0]          num_input,
    output logic [$clog2(`IB_DEPTH+1)-1:0]       ib_open,
    output isa_pkg::commit_t [`WIDTH-1:0]        commit
);

    isa_pkg::inst_t [`WIDTH-1:0]            ib_head;
    logic [$clog2(`IB_DEPTH+1)-1:0]         ib_count;
    logic [$clog2(`WIDTH+1)-1:0]            num_dispatch;

    uarch_pkg::phys_idx_t [`WIDTH-1:0]      src1_phys, src2_phys, t_new, t_old;
    logic [$clog2(`ROB_DEPTH+1)-1:0]        free_count;
    logic [`PHYS_REGS-1:0]                  phys_ready;
    uarch_pkg::phys_idx_t [2*`WIDTH-1:0]    rf_idx;
    isa_pkg::data_t [2*`WIDTH-1:0]          rf_data;

    logic [$clog2(`ROB_DEPTH+1)-1:0]        rob_open;
    uarch_pkg::rob_entry_t [`WIDTH-1:0]     rob_alloc;
    uarch_pkg::rob_idx_t [`WIDTH-1:0]       rob_slots;
    logic [$clog2(`WIDTH+1)-1:0]            retire_count;
    uarch_pkg::phys_idx_t [`WIDTH-1:0]      retire_t_old;

    uarch_pkg::exec_op_t [`WIDTH-1:0]       exec_ops;
    logic [`WIDTH-1:0]                      wb_valid;
    uarch_pkg::phys_idx_t [`WIDTH-1:0]      wb_idx;
    uarch_pkg::rob_idx_t [`WIDTH-1:0]       wb_slot;
    isa_pkg::data_t [`WIDTH-1:0]            wb_data;

    inst_buffer u_inst_buffer (
        .clock(clock), .reset(reset),
        .push_insts(in_insts), .push_count(num_input), .pop_count(num_dispatch),
        .head_insts(ib_head), .count(ib_count), .open(ib_open)
    );

    dispatch_select u_dispatch_select (
        .head_insts(ib_head), .head_count(ib_count),
        .rob_open(rob_open), .free_count(free_count),
        .src1_phys(src1_phys), .src2_phys(src2_phys), .phys_ready(phys_ready),
        .num_dispatch(num_dispatch)
    );

    rename_unit u_rename_unit (
        .clock(clock), .reset(reset),
        .insts(ib_head), .num_dispatch(num_dispatch),
        .retire_count(retire_count), .retire_t_old(retire_t_old),
        .src1_phys(src1_phys), .src2_phys(src2_phys),
        .t_new(t_new), .t_old(t_old), .free_count(free_count)
    );

    phys_regfile u_phys_regfile (
        .clock(clock), .reset(reset),
        .read_idx(rf_idx), .read_data(rf_data), .ready(phys_ready),
        .alloc_idx(t_new), .alloc_count(num_dispatch),
        .wb_valid(wb_valid), .wb_idx(wb_idx), .wb_data(wb_data)
    );

    reorder_buffer u_reorder_buffer (
        .clock(clock), .reset(reset),
        .alloc_entries(rob_alloc), .alloc_count(num_dispatch),
        .alloc_slots(rob_slots), .open(rob_open),
        .wb_valid(wb_valid), .wb_slot(wb_slot), .wb_data(wb_data),
        .commit(commit), .retire_count(retire_count), .retire_t_old(retire_t_old)
    );

    //////////////////////////////////////////////////
    // per-lane operand read and issue
    //////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < `WIDTH; i++) begin
            rf_idx[2*i]   = src1_phys[i];
            rf_idx[2*i+1] = src2_phys[i];

            rob_alloc[i].dest  = ib_head[i].dest;
            rob_alloc[i].t_new = t_new[i];
            rob_alloc[i].t_old = t_old[i];
            rob_alloc[i].done  = 1'b0;

            exec_ops[i].valid    = (i < num_dispatch);
            exec_ops[i].opcode   = ib_head[i].opcode;
            exec_ops[i].t_new    = t_new[i];
            exec_ops[i].rob_slot = rob_slots[i];
            exec_ops[i].op_a     = rf_data[2*i];
            exec_ops[i].op_b     = (ib_head[i].opcode == isa_pkg::op_li) ?
                                   ib_head[i].imm[`IMM_BITS-1:0] : rf_data[2*i+1];
        end
    end

    for (genvar i = 0; i < `WIDTH; i++) begin : g_alu
        alu_lane u_alu_lane (
            .clock(clock), .reset(reset), .op_in(exec_ops[i]),
            .wb_valid(wb_valid[i]), .wb_idx(wb_idx[i]),
            .wb_slot(wb_slot[i]), .wb_data(wb_data[i])
        );
    end

endmodule

// ==== dv/rename_core_tb.sv ====
//////////////////////////////////////////////////
// rename core testbench
// random programs, in-order reference model and
// commit checks by concurrent assertions
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "core_macros.svh"

module rename_core_tb;

    localparam int MAX_INSTS = 1024;

    logic                              clock;
    logic                              reset;
    isa_pkg::inst_t [`WIDTH-1:0]       in_insts;
    logic [$clog2(`WIDTH+1)-1:0]       num_input;
    logic [$clog2(`IB_DEPTH+1)-1:0]    ib_open;
    isa_pkg::commit_t [`WIDTH-1:0]     commit;

    isa_pkg::inst_t   prog [$];               // generated and not yet sent
    isa_pkg::commit_t exp_mem [MAX_INSTS];    // expected commits in program order
    isa_pkg::data_t   arch_regs [`ARCH_REGS];
    isa_pkg::commit_t exp_lane0;
    isa_pkg::commit_t exp_lane1;

    int    exp_count = 0;
    int    check_idx = 0;     // commits seen so far
    int    sent_total = 0;
    int    cycles = 0;
    int    errors = 0;
    int    tests = 0;
    int    min_open;
    int    first_sent;
    int    first_err;
    logic  reset_check = 1'b0;
    string test_name = "reset";

    rename_core u_rename_core (
        .clock(clock), .reset(reset),
        .in_insts(in_insts), .num_input(num_input),
        .ib_open(ib_open), .commit(commit)
    );

    always #2 clock = ~clock;

    always @(posedge clock) begin
        if (reset) check_idx <= 0;
        else check_idx <= check_idx + int'(commit[0].valid) + int'(commit[1].valid);
    end

    assign exp_lane0 = exp_mem[check_idx % MAX_INSTS];
    assign exp_lane1 = exp_mem[(check_idx + 1) % MAX_INSTS];

    // run limit grows with the work handed to the core
    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles > 20 * sent_total + 100) begin
            $display("timeout in test %s after %0d cycles, %0d of %0d committed",
                     test_name, cycles, check_idx, exp_count);
            $display(">>> FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // commit checks
    //////////////////////////////////////////////////

    a_reset_state: assert property (@(posedge clock) reset_check |->
        (!commit[0].valid && !commit[1].valid && ib_open == `IB_DEPTH))
        else begin
            $display("core not idle after reset, ib_open %0d", $sampled(ib_open));
            errors++;
        end

    a_lane0: assert property (@(posedge clock) disable iff (reset)
        commit[0].valid |-> commit[0] == exp_lane0)
        else begin
            $display("error %s lane 0 expected r%0d=%h actual r%0d=%h", test_name,
                     $sampled(exp_lane0.dest), $sampled(exp_lane0.data),
                     $sampled(commit[0].dest), $sampled(commit[0].data));
            errors++;
        end

    a_lane1: assert property (@(posedge clock) disable iff (reset)
        commit[1].valid |-> commit[1] == exp_lane1)
        else begin
            $display("error %s lane 1 expected r%0d=%h actual r%0d=%h", test_name,
                     $sampled(exp_lane1.dest), $sampled(exp_lane1.data),
                     $sampled(commit[1].dest), $sampled(commit[1].data));
            errors++;
        end

    a_lanes_fill: assert property (@(posedge clock) disable iff (reset)
        commit[1].valid |-> commit[0].valid)
        else begin
            $display("commit lane 1 valid while lane 0 idle in test %s", test_name);
            errors++;
        end

    //////////////////////////////////////////////////
    // reference model and programs
    //////////////////////////////////////////////////

    function automatic void model_exec(isa_pkg::inst_t inst);
        isa_pkg::data_t a;
        isa_pkg::data_t b;
        isa_pkg::data_t result;
        a = arch_regs[inst.src1];
        b = arch_regs[inst.src2];
        case (inst.opcode)
            isa_pkg::op_add: result = a + b;
            isa_pkg::op_sub: result = a - b;
            isa_pkg::op_xor: result = a ^ b;
            default:         result = inst.imm;
        endcase
        arch_regs[inst.dest] = result;
        exp_mem[exp_count] = '{1'b1, inst.dest, result};
        exp_count++;
    endfunction

    function automatic void add_inst(int op, int dest, int src1, int src2, int imm);
        isa_pkg::inst_t inst;
        inst.valid  = 1'b1;
        inst.opcode = isa_pkg::opcode_t'(op);
        inst.dest   = isa_pkg::arch_idx_t'(dest);
        inst.src1   = isa_pkg::arch_idx_t'(src1);
        inst.src2   = isa_pkg::arch_idx_t'(src2);
        inst.imm    = isa_pkg::data_t'(imm);
        prog.push_back(inst);
        model_exec(inst);
    endfunction

    function automatic void load_imm_program(int n);
        for (int i = 0; i < n; i++) begin
            add_inst(isa_pkg::op_li, $urandom_range(`ARCH_REGS-1, 0), 0, 0, $urandom);
        end
    endfunction

    // src1 follows the last result and often sits in the same dispatch group
    function automatic void dep_chain_program(int n);
        int last;
        int dest;
        last = 0;
        for (int i = 0; i < n; i++) begin
            dest = $urandom_range(`ARCH_REGS-1, 0);
            add_inst($urandom_range(3, 0), dest, last, $urandom_range(`ARCH_REGS-1, 0),
                     $urandom);
            last = dest;
        end
    endfunction

    function automatic void serial_chain_program(int n);
        add_inst(isa_pkg::op_li, 1, 0, 0, $urandom);
        for (int i = 1; i < n; i++) begin
            add_inst($urandom_range(2, 0), (i % 7) + 1, ((i - 1) % 7) + 1, i % 7, 0);
        end
    endfunction

    function automatic void mixed_random_program(int n);
        for (int i = 0; i < n; i++) begin
            add_inst($urandom_range(3, 0), $urandom_range(`ARCH_REGS-1, 0),
                     $urandom_range(`ARCH_REGS-1, 0), $urandom_range(`ARCH_REGS-1, 0),
                     $urandom);
        end
    endfunction

    //////////////////////////////////////////////////
    // test flow
    //////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic send_program(bit full_rate);
        int n;
        while (prog.size() > 0) begin
            n = (ib_open < `WIDTH) ? int'(ib_open) : `WIDTH;
            if (n > prog.size()) n = prog.size();
            if (!full_rate) n = $urandom_range(n, 0);
            in_insts = '0;
            for (int i = 0; i < n; i++) in_insts[i] = prog.pop_front();
            num_input = n[$clog2(`WIDTH+1)-1:0];
            sent_total += n;
            if (ib_open < min_open) min_open = ib_open;
            next_cycle();
        end
        num_input = '0;
        in_insts  = '0;
    endtask

    task automatic wait_commits();
        while (check_idx < exp_count) next_cycle();
        repeat (4) next_cycle();   // room for a stray extra commit
    endtask

    task automatic start_test(string name);
        test_name  = name;
        first_sent = sent_total;
        first_err  = errors;
        min_open   = `IB_DEPTH;
    endtask

    task automatic finish_test();
        tests++;
        a_count: assert (check_idx == sent_total) else begin
            $display("test %s: %0d committed but %0d sent", test_name, check_idx, sent_total);
            errors++;
        end
        $display("test %s done: %0d sent, %0d errors", test_name,
                 sent_total - first_sent, errors - first_err);
    endtask

    initial begin
        void'($urandom(32'h7f76_934a));
        for (int i = 0; i < MAX_INSTS; i++) exp_mem[i] = '0;
        for (int i = 0; i < `ARCH_REGS; i++) arch_regs[i] = '0;
        clock     = 1'b0;
        reset     = 1'b1;
        in_insts  = '0;
        num_input = '0;
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;

        start_test("reset");
        reset_check = 1'b1;    // first edge out of reset
        next_cycle();
        reset_check = 1'b0;
        finish_test();

        start_test("load_imm");
        load_imm_program(24);
        send_program(1'b0);
        wait_commits();
        finish_test();

        start_test("dep_chains");
        dep_chain_program(40);
        send_program(1'b0);
        wait_commits();
        finish_test();

        start_test("backpressure");
        serial_chain_program(60);
        send_program(1'b1);
        wait_commits();
        a_buffer_filled: assert (min_open < `WIDTH) else begin
            $display("test %s: ib_open never dropped below %0d, lowest %0d",
                     test_name, `WIDTH, min_open);
            errors++;
        end
        finish_test();

        start_test("recycle");
        mixed_random_program(300);
        send_program(1'b0);
        wait_commits();
        finish_test();

        $display("tests %0d, commits checked %0d, errors %0d", tests, check_idx, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== rename_core.f ====
+incdir+verilog
verilog/isa_pkg.sv
verilog/uarch_pkg.sv
verilog/inst_buffer.sv
verilog/dispatch_select.sv
verilog/rename_unit.sv
verilog/phys_regfile.sv
verilog/alu_lane.sv
verilog/reorder_buffer.sv
verilog/rename_core.sv
dv/rename_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the rename core testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f rename_core.f --top-module rename_core_tb -o rename_core_sim

# a nonzero exit from the simulation also ends without the pass line
out=$(./obj_dir/rename_core_sim) || true
echo "$out"

if echo "$out" | grep -qx -- '>>> PASS'; then
    exit 0
fi
exit 1
